//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_ex_mem_backend
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "Test passed" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- flist.f
hw/mips_pkg.sv
hw/ex_alu.sv
hw/ex_stage.sv
hw/ex_mem_reg.sv
hw/data_memory.sv
hw/mem_stage.sv
hw/ex_mem_backend.sv
verif/tb_ex_mem_backend.sv

//--- hw/data_memory.sv
`timescale 1ns/1ns

module data_memory
(
    input  logic                         i_clk,
    input  logic                         i_we,
    input  logic [mips_pkg::DMEM_AW-1:0] i_addr,
    input  mips_pkg::word_t              i_wdata,
    output mips_pkg::word_t              o_rdata
);

    mips_pkg::word_t mem [mips_pkg::DMEM_WORDS];

    always_ff @(posedge i_clk)
    begin
        if (i_we)
        begin
            mem[i_addr] <= i_wdata;
        end
    end

    // Read path has no clock
    assign o_rdata = mem[i_addr];

endmodule

//--- hw/ex_alu.sv
`timescale 1ns/1ns

module ex_alu
(
    input  mips_pkg::word_t   i_a,
    input  mips_pkg::word_t   i_b,
    input  mips_pkg::alu_op_t i_alu_op,
    input  mips_pkg::funct_t  i_funct,
    output mips_pkg::word_t   o_result,
    output logic              o_zero
);

    mips_pkg::alu_fn_t alu_fn;
    logic              less_than;

    // ALU control from main op and function field
    always_comb
    begin
        case (i_alu_op)
            mips_pkg::ALU_OP_ADD:
            begin
                alu_fn = mips_pkg::ALU_ADD;
            end
            mips_pkg::ALU_OP_SUB:
            begin
                alu_fn = mips_pkg::ALU_SUB;
            end
            mips_pkg::ALU_OP_FUNCT:
            begin
                case (i_funct)
                    mips_pkg::FUNCT_ADD: alu_fn = mips_pkg::ALU_ADD;
                    mips_pkg::FUNCT_SUB: alu_fn = mips_pkg::ALU_SUB;
                    mips_pkg::FUNCT_AND: alu_fn = mips_pkg::ALU_AND;
                    mips_pkg::FUNCT_OR:  alu_fn = mips_pkg::ALU_OR;
                    mips_pkg::FUNCT_NOR: alu_fn = mips_pkg::ALU_NOR;
                    mips_pkg::FUNCT_SLT: alu_fn = mips_pkg::ALU_SLT;
                    // Unknown codes behave as add
                    default:             alu_fn = mips_pkg::ALU_ADD;
                endcase
            end
            default:
            begin
                alu_fn = mips_pkg::ALU_ADD;
            end
        endcase
    end

    // Signed compare for slt
    assign less_than = ($signed(i_a) < $signed(i_b));

    always_comb
    begin
        case (alu_fn)
            mips_pkg::ALU_AND:
            begin
                o_result = i_a & i_b;
            end
            mips_pkg::ALU_OR:
            begin
                o_result = i_a | i_b;
            end
            mips_pkg::ALU_ADD:
            begin
                o_result = i_a + i_b;
            end
            mips_pkg::ALU_SUB:
            begin
                o_result = i_a - i_b;
            end
            mips_pkg::ALU_SLT:
            begin
                o_result = {31'b0, less_than};
            end
            mips_pkg::ALU_NOR:
            begin
                o_result = ~(i_a | i_b);
            end
            default:
            begin
                o_result = i_a + i_b;
            end
        endcase
    end

    assign o_zero = (o_result == '0);

endmodule

//--- hw/ex_mem_backend.sv
`timescale 1ns/1ns

module ex_mem_backend
(
    input  logic                i_clk,
    input  logic                i_arst_n,
    input  mips_pkg::id_ex_t    i_id_ex,
    output mips_pkg::word_t     o_wb_data,
    output mips_pkg::reg_addr_t o_wb_addr,
    output logic                o_reg_write,
    output logic                o_pc_src,
    output mips_pkg::word_t     o_branch_target
);

    mips_pkg::ex_mem_t ex_result;
    mips_pkg::ex_mem_t ex_mem;

    ex_stage u_ex_stage
    (
        .i_id_ex  (i_id_ex),
        .o_ex_mem (ex_result)
    );

    ex_mem_reg u_ex_mem_reg
    (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_ex_mem (ex_result),
        .o_ex_mem (ex_mem)
    );

    mem_stage u_mem_stage
    (
        .i_clk           (i_clk),
        .i_ex_mem        (ex_mem),
        .o_wb_data       (o_wb_data),
        .o_wb_addr       (o_wb_addr),
        .o_reg_write     (o_reg_write),
        .o_pc_src        (o_pc_src),
        .o_branch_target (o_branch_target)
    );

endmodule

//--- hw/ex_mem_reg.sv
`timescale 1ns/1ns

module ex_mem_reg
(
    input  logic              i_clk,
    input  logic              i_arst_n,
    input  mips_pkg::ex_mem_t i_ex_mem,
    output mips_pkg::ex_mem_t o_ex_mem
);

    // Whole bundle cleared on reset
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_ex_mem <= '0;
        end
        else
        begin
            o_ex_mem <= i_ex_mem;
        end
    end

endmodule

//--- hw/ex_stage.sv
`timescale 1ns/1ns

module ex_stage
(
    input  mips_pkg::id_ex_t  i_id_ex,
    output mips_pkg::ex_mem_t o_ex_mem
);

    mips_pkg::word_t     operand_b;
    mips_pkg::word_t     alu_result;
    logic                alu_zero;
    mips_pkg::word_t     branch_target;
    mips_pkg::reg_addr_t dest_addr;

    // Immediate or rt as second operand
    assign operand_b = i_id_ex.ex.alu_src ? i_id_ex.imm : i_id_ex.rt_data;

    ex_alu u_alu
    (
        .i_a      (i_id_ex.rs_data),
        .i_b      (operand_b),
        .i_alu_op (i_id_ex.ex.alu_op),
        .i_funct  (i_id_ex.imm[5:0]),
        .o_result (alu_result),
        .o_zero   (alu_zero)
    );

    // Word offset turned into a byte offset
    assign branch_target = i_id_ex.pc_plus4 + {i_id_ex.imm[29:0], 2'b00};

    // R-type writes rd, I-type writes rt
    assign dest_addr = i_id_ex.ex.reg_dst ? i_id_ex.rd_addr : i_id_ex.rt_addr;

    always_comb
    begin
        o_ex_mem.branch_target = branch_target;
        o_ex_mem.zero          = alu_zero;
        o_ex_mem.alu_result    = alu_result;
        o_ex_mem.store_data    = i_id_ex.rt_data;
        o_ex_mem.dest_addr     = dest_addr;
        o_ex_mem.mem           = i_id_ex.mem;
        o_ex_mem.wb            = i_id_ex.wb;
    end

endmodule

//--- hw/mem_stage.sv
`timescale 1ns/1ns

module mem_stage
(
    input  logic                i_clk,
    input  mips_pkg::ex_mem_t   i_ex_mem,
    output mips_pkg::word_t     o_wb_data,
    output mips_pkg::reg_addr_t o_wb_addr,
    output logic                o_reg_write,
    output logic                o_pc_src,
    output mips_pkg::word_t     o_branch_target
);

    logic [mips_pkg::DMEM_AW-1:0] mem_addr;
    mips_pkg::word_t              mem_rdata;

    // Byte address to word index
    assign mem_addr = i_ex_mem.alu_result[mips_pkg::DMEM_AW+1:2];

    data_memory u_dmem
    (
        .i_clk   (i_clk),
        .i_we    (i_ex_mem.mem.mem_write),
        .i_addr  (mem_addr),
        .i_wdata (i_ex_mem.store_data),
        .o_rdata (mem_rdata)
    );

    // beq taken when operands were equal
    assign o_pc_src        = i_ex_mem.mem.branch & i_ex_mem.zero;
    assign o_branch_target = i_ex_mem.branch_target;

    assign o_wb_data   = i_ex_mem.wb.mem_to_reg ? mem_rdata : i_ex_mem.alu_result;
    assign o_wb_addr   = i_ex_mem.dest_addr;
    assign o_reg_write = i_ex_mem.wb.reg_write;

endmodule

//--- hw/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  funct_t;

    // Data memory geometry, word addressed
    localparam int DMEM_WORDS = 64;
    localparam int DMEM_AW    = 6;

    // R-type function field codes
    localparam funct_t FUNCT_ADD = 6'h20;
    localparam funct_t FUNCT_SUB = 6'h22;
    localparam funct_t FUNCT_AND = 6'h24;
    localparam funct_t FUNCT_OR  = 6'h25;
    localparam funct_t FUNCT_NOR = 6'h27;
    localparam funct_t FUNCT_SLT = 6'h2A;

    // Main control ALU op
    typedef enum logic [1:0] {
        ALU_OP_ADD   = 2'b00,
        ALU_OP_SUB   = 2'b01,
        ALU_OP_FUNCT = 2'b10
    } alu_op_t;

    typedef enum logic [3:0] {
        ALU_AND = 4'b0000,
        ALU_OR  = 4'b0001,
        ALU_ADD = 4'b0010,
        ALU_SUB = 4'b0110,
        ALU_SLT = 4'b0111,
        ALU_NOR = 4'b1100
    } alu_fn_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    alu_src;
        logic    reg_dst;
    } ex_ctrl_t;

    typedef struct packed {
        logic branch;
        logic mem_write;
        logic mem_read;
    } mem_ctrl_t;

    typedef struct packed {
        logic mem_to_reg;
        logic reg_write;
    } wb_ctrl_t;

    // Bundle from the decode stage
    typedef struct packed {
        word_t     pc_plus4;
        word_t     rs_data;
        word_t     rt_data;
        word_t     imm;
        reg_addr_t rt_addr;
        reg_addr_t rd_addr;
        ex_ctrl_t  ex;
        mem_ctrl_t mem;
        wb_ctrl_t  wb;
    } id_ex_t;

    typedef struct packed {
        word_t     branch_target;
        logic      zero;
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t dest_addr;
        mem_ctrl_t mem;
        wb_ctrl_t  wb;
    } ex_mem_t;

endpackage

//--- verif/ex_mem_patterns.txt
// pc_plus4 rs_data rt_data imm rt rd ex mem wb, then expected wb_data wb_addr reg_write pc_src target care
// ex = {alu_op, alu_src, reg_dst}, mem = {branch, mem_write, mem_read}, wb = {mem_to_reg, reg_write}
// care bit 0 checks wb_data, bit 1 wb_addr, bit 2 branch_target

// R-type
00000004 00000005 00000007 00001820 02 03 9 0 1 0000000c 03 1 0 00000000 3 // add
00000008 0000000a 00000003 00002022 02 04 9 0 1 00000007 04 1 0 00000000 3 // sub
0000000c f0f0f0f0 ff00ff00 00002824 02 05 9 0 1 f000f000 05 1 0 00000000 3 // and
00000010 f0f0f0f0 0f000f00 00003025 02 06 9 0 1 fff0fff0 06 1 0 00000000 3 // or
00000014 0000ffff 00ff0000 00003827 02 07 9 0 1 ff000000 07 1 0 00000000 3 // nor
00000018 fffffff0 00000005 0000402a 02 08 9 0 1 00000001 08 1 0 00000000 3 // slt -16 < 5
0000001c 00000005 fffffff0 0000482a 02 09 9 0 1 00000000 09 1 0 00000000 3 // slt 5 < -16
00000020 00000009 00000009 00005022 02 0a 9 0 1 00000000 0a 1 0 00000000 3 // zero, no branch
00000024 7fffffff 00000001 00005820 02 0b 9 0 1 80000000 0b 1 0 00000000 3 // add wraps

// addi rt = rs + imm
00000028 00000064 00000000 fffffffc 0c 00 2 0 1 00000060 0c 1 0 00000000 3

// Word 4 stored and loaded back next cycle, then word 8
0000002c 00000100 12345678 00000010 0d 00 2 2 0 00000000 00 0 0 00000000 0 // sw A
00000030 00000100 00000000 00000010 0e 00 2 1 3 12345678 0e 1 0 00000000 3 // lw A
00000034 00000100 cafef00d 00000020 0f 00 2 2 0 00000000 00 0 0 00000000 0 // sw B
00000038 00000100 00000000 00000010 10 00 2 1 3 12345678 10 1 0 00000000 3 // lw A
0000003c 00000100 00000000 00000020 11 00 2 1 3 cafef00d 11 1 0 00000000 3 // lw B

// beq
00000040 00000033 00000033 00000005 03 00 4 4 0 00000000 00 0 1 00000054 4 // taken
00000080 0000abcd 0000abcd fffffffc 03 00 4 4 0 00000000 00 0 1 00000070 4 // taken, back
000000a0 00000001 00000002 00000008 03 00 4 4 0 00000000 00 0 0 00000000 0 // not taken

// Store with a zero address result, then its load
000000a4 00000000 deadbeef 00000000 12 00 2 2 0 00000000 00 0 0 00000000 0
000000a8 00000000 00000000 00000000 13 00 2 1 3 deadbeef 13 1 0 00000000 3
000000ac 00000011 00000022 0000f820 02 1f 9 0 1 00000033 1f 1 0 00000000 3 // add to r31

//--- verif/tb_ex_mem_backend.sv
`timescale 1ns/1ns

module tb_ex_mem_backend;

    localparam int CLK_PERIOD   = 4;
    localparam int FIELDS       = 15;
    localparam int MAX_PATTERNS = 64;

    // Column of each field within a pattern record
    localparam int F_PC_PLUS4 = 0;
    localparam int F_RS_DATA  = 1;
    localparam int F_RT_DATA  = 2;
    localparam int F_IMM      = 3;
    localparam int F_RT_ADDR  = 4;
    localparam int F_RD_ADDR  = 5;
    localparam int F_EX       = 6;
    localparam int F_MEM      = 7;
    localparam int F_WB       = 8;
    localparam int F_WB_DATA  = 9;
    localparam int F_WB_ADDR  = 10;
    localparam int F_REG_WR   = 11;
    localparam int F_PC_SRC   = 12;
    localparam int F_TARGET   = 13;
    localparam int F_CARE     = 14;

    logic                clk;
    logic                arst_n;
    mips_pkg::id_ex_t    id_ex;
    mips_pkg::word_t     wb_data;
    mips_pkg::reg_addr_t wb_addr;
    logic                reg_write;
    logic                pc_src;
    mips_pkg::word_t     branch_target;

    logic [31:0] pattern_mem [MAX_PATTERNS*FIELDS];
    int          num_patterns;
    int          error_count;
    int          check_count;
    logic        patterns_loaded;

    ex_mem_backend DUT
    (
        .i_clk           (clk),
        .i_arst_n        (arst_n),
        .i_id_ex         (id_ex),
        .o_wb_data       (wb_data),
        .o_wb_addr       (wb_addr),
        .o_reg_write     (reg_write),
        .o_pc_src        (pc_src),
        .o_branch_target (branch_target)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        check_count++;
        assert (actual === expected)
        else
        begin
            error_count++;
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        check_count++;
        assert (actual === expected)
        else
        begin
            error_count++;
            $display("Fail at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    // Unused entries hold a word unique to their index
    function automatic logic [31:0] fill_word(input int addr);
        return 32'hffff_0000 | 32'(addr);
    endfunction

    task automatic load_patterns();
        int i;
        int rec;
        for (i = 0; i < MAX_PATTERNS*FIELDS; i++)
        begin
            pattern_mem[i] = fill_word(i);
        end
        $readmemh("verif/ex_mem_patterns.txt", pattern_mem);
        // Records end where the care column still holds its fill word
        rec = 0;
        while (rec < MAX_PATTERNS
               && pattern_mem[rec*FIELDS + F_CARE] != fill_word(rec*FIELDS + F_CARE))
        begin
            rec++;
        end
        num_patterns = rec;
    endtask

    task automatic apply_record(input int rec);
        int base;
        base = rec * FIELDS;
        id_ex.pc_plus4 = pattern_mem[base + F_PC_PLUS4];
        id_ex.rs_data  = pattern_mem[base + F_RS_DATA];
        id_ex.rt_data  = pattern_mem[base + F_RT_DATA];
        id_ex.imm      = pattern_mem[base + F_IMM];
        id_ex.rt_addr  = pattern_mem[base + F_RT_ADDR][4:0];
        id_ex.rd_addr  = pattern_mem[base + F_RD_ADDR][4:0];
        id_ex.ex       = pattern_mem[base + F_EX][3:0];
        id_ex.mem      = pattern_mem[base + F_MEM][2:0];
        id_ex.wb       = pattern_mem[base + F_WB][1:0];
    endtask

    // Nothing may be written or taken
    task automatic check_idle();
        check_bit("o_reg_write", 1'b0, reg_write);
        check_bit("o_pc_src", 1'b0, pc_src);
    endtask

    task automatic check_record(input int rec);
        int         base;
        logic [2:0] care;
        base = rec * FIELDS;
        care = pattern_mem[base + F_CARE][2:0];
        check_bit("o_reg_write", pattern_mem[base + F_REG_WR][0], reg_write);
        check_bit("o_pc_src", pattern_mem[base + F_PC_SRC][0], pc_src);
        if (care[0])
        begin
            check_word("o_wb_data", pattern_mem[base + F_WB_DATA], wb_data);
        end
        if (care[1])
        begin
            check_word("o_wb_addr", pattern_mem[base + F_WB_ADDR], {27'b0, wb_addr});
        end
        if (care[2])
        begin
            check_word("o_branch_target", pattern_mem[base + F_TARGET], branch_target);
        end
    endtask

    initial
    begin
        int i;
        clk             = 1'b0;
        arst_n          = 1'b0;
        id_ex           = '0;
        error_count     = 0;
        check_count     = 0;
        num_patterns    = 0;
        patterns_loaded = 1'b0;

        load_patterns();
        patterns_loaded = 1'b1;
        assert (num_patterns > 0)
        else
        begin
            error_count++;
            $display("No records could be read from verif/ex_mem_patterns.txt");
        end

        // A bundle that would write and branch if the register were not held
        @(posedge clk);
        #1;
        id_ex.ex.alu_op    = mips_pkg::ALU_OP_SUB;
        id_ex.mem.branch   = 1'b1;
        id_ex.wb.reg_write = 1'b1;
        @(posedge clk);
        #1;
        check_idle();
        arst_n = 1'b1;
        id_ex  = '0;
        #1;
        check_idle();

        // Record i goes in after edge i, its outputs are checked before edge i+2
        for (i = 0; i <= num_patterns; i++)
        begin
            @(posedge clk);
            #1;
            if (i < num_patterns)
            begin
                apply_record(i);
            end
            else
            begin
                id_ex = '0;
            end
            #2;
            if (i == 0)
            begin
                check_idle();
            end
            else
            begin
                check_record(i - 1);
            end
        end

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("Test passed");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

    initial
    begin
        wait (patterns_loaded);
        #((num_patterns + 10) * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d ns",
                 (num_patterns + 10) * CLK_PERIOD);
        $display("Test failed");
        $finish;
    end

endmodule
